/* Makefile */
TOP = soc_bus_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f soc_bus.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee run.log
	@if grep -q "Test FAILED" run.log || ! grep -q "Test OK" run.log; then \
		echo "simulation reported a failure, see run.log"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f soc_bus.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

/* hw/bus_decode.sv */
`include "soc_bus_defs.svh"

module bus_decode import soc_bus_pkg::*; (
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  bus_addr_u          adr,
    input  logic [`BUS_DW-1:0] dat_w,
    input  logic [`BUS_SW-1:0] sel,
    output logic               miss_stb,
    wb_if.master               ram_m,
    wb_if.master               ext_m,
    wb_if.master               sys_m
);

    logic ram_hit;
    logic ext_hit;
    logic sys_hit;

    // one tag compare for the whole map
    always_comb begin
        ram_hit = 1'b0;
        ext_hit = 1'b0;
        sys_hit = 1'b0;
        case (adr.fields.tag)
            `TAG_RAM: ram_hit = 1'b1;
            `TAG_EXT: ext_hit = 1'b1;
            `TAG_SYS: sys_hit = 1'b1;
            default: ;  // unmapped, goes to miss_stb
        endcase
    end

    // request fans out to every slave, only stb is routed
    assign ram_m.cyc   = cyc;
    assign ram_m.we    = we;
    assign ram_m.adr   = adr;
    assign ram_m.dat_w = dat_w;
    assign ram_m.sel   = sel;
    assign ram_m.stb   = stb & ram_hit;

    assign ext_m.cyc   = cyc;
    assign ext_m.we    = we;
    assign ext_m.adr   = adr;
    assign ext_m.dat_w = dat_w;
    assign ext_m.sel   = sel;
    assign ext_m.stb   = stb & ext_hit;

    assign sys_m.cyc   = cyc;
    assign sys_m.we    = we;
    assign sys_m.adr   = adr;
    assign sys_m.dat_w = dat_w;
    assign sys_m.sel   = sel;
    assign sys_m.stb   = stb & sys_hit;

    assign miss_stb = cyc & stb & ~(ram_hit | ext_hit | sys_hit);

endmodule

/* hw/bus_result.sv */
`include "soc_bus_defs.svh"

module bus_result (
    input  logic               clk,
    input  logic               rst,
    input  logic               miss_stb,
    wb_if.monitor              ram_r,
    wb_if.monitor              ext_r,
    wb_if.monitor              sys_r,
    output logic [`BUS_DW-1:0] dat_r,
    output logic               ack,
    output logic               err
);

    logic [`BUS_DW-1:0] dat_sel;
    logic [`BUS_DW-1:0] dat_old;  // last word returned
    logic               err_q;

    // slaves only ack their own strobe, so a plain OR is enough
    assign ack = ram_r.ack | ext_r.ack | sys_r.ack;

    always_comb begin
        if (ram_r.ack) begin
            dat_sel = ram_r.dat_r;
        end else if (ext_r.ack) begin
            dat_sel = ext_r.dat_r;
        end else if (sys_r.ack) begin
            dat_sel = sys_r.dat_r;
        end else begin
            dat_sel = '0;
        end
    end

    // error for an unmapped address, one-cycle pulse like an ack
    always_ff @(posedge clk) begin
        if (rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= miss_stb & ~err_q;
        end
    end

    always_ff @(posedge clk) begin
        if (ack) begin
            dat_old <= dat_sel;
        end
    end

    assign err   = err_q;
    assign dat_r = ack ? dat_sel : (err_q ? '0 : dat_old);  // zero on error

endmodule

/* hw/data_ram.sv */
`include "soc_bus_defs.svh"

module data_ram (
    input  logic clk,
    input  logic rst,
    wb_if.slave  bus
);

    localparam int IW = $clog2(`RAM_WORDS);

    logic [`BUS_DW-1:0] mem [`RAM_WORDS];
    logic [IW-1:0]      idx;
    logic               go;
    logic [`BUS_DW-1:0] rd_q;
    logic               ack_q;

    // word index, wraps at the region depth
    assign idx = bus.adr.fields.offset[IW+1:2];

    // serve in the first cycle of stb, not again while ack is out
    assign go = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= go;  // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            if (bus.we) begin
                for (int b = 0; b < `BUS_SW; b++) begin
                    if (bus.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end else begin
                rd_q <= mem[idx];  // whole word, sel ignored on reads
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_q;

endmodule

/* hw/ext_mem.sv */
`include "soc_bus_defs.svh"

module ext_mem (
    input  logic clk,
    input  logic rst,
    wb_if.slave  bus
);

    localparam int IW = $clog2(`EXT_WORDS);
    localparam int CW = $clog2(`EXT_WAIT + 1);
    localparam logic [CW-1:0] LAST = CW'(`EXT_WAIT);

    logic [`BUS_DW-1:0] mem [`EXT_WORDS];
    logic [IW-1:0]      idx;
    logic [CW-1:0]      wait_cnt;
    logic               req;
    logic               go;
    logic [`BUS_DW-1:0] rd_q;
    logic               ack_q;

    assign idx = bus.adr.fields.offset[IW+1:2];
    assign req = bus.cyc & bus.stb & ~ack_q;
    assign go  = req & (wait_cnt == LAST);  // last wait state done

    // wait counter, cleared by ack or a dropped strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else if (go) begin
            wait_cnt <= '0;
            ack_q    <= 1'b1;
        end else if (req) begin
            wait_cnt <= wait_cnt + 1'b1;
            ack_q    <= 1'b0;
        end else begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            if (bus.we) begin
                for (int b = 0; b < `BUS_SW; b++) begin
                    if (bus.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end else begin
                rd_q <= mem[idx];
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_q;

endmodule

/* hw/soc_bus.sv */
`include "soc_bus_defs.svh"

module soc_bus import soc_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [`BUS_AW-1:0] adr,
    input  logic [`BUS_DW-1:0] dat_w,
    input  logic [`BUS_SW-1:0] sel,
    input  logic               btn,
    output logic [`BUS_DW-1:0] dat_r,
    output logic               ack,
    output logic               err
);

    bus_addr_u adr_u;
    logic      miss_stb;

    assign adr_u.word = adr;

    wb_if ram_bus ();
    wb_if ext_bus ();
    wb_if sys_bus ();

    bus_decode u_decode (
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr_u),
        .dat_w    (dat_w),
        .sel      (sel),
        .miss_stb (miss_stb),
        .ram_m    (ram_bus.master),
        .ext_m    (ext_bus.master),
        .sys_m    (sys_bus.master)
    );

    data_ram u_ram (.clk(clk), .rst(rst), .bus(ram_bus.slave));

    ext_mem u_ext (.clk(clk), .rst(rst), .bus(ext_bus.slave));

    sys_regs u_sys (.clk(clk), .rst(rst), .btn(btn), .bus(sys_bus.slave));

    bus_result u_result (
        .clk      (clk),
        .rst      (rst),
        .miss_stb (miss_stb),
        .ram_r    (ram_bus.monitor),
        .ext_r    (ext_bus.monitor),
        .sys_r    (sys_bus.monitor),
        .dat_r    (dat_r),
        .ack      (ack),
        .err      (err)
    );

endmodule

/* hw/soc_bus_defs.svh */
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

// bus widths
`define BUS_AW 32
`define BUS_DW 32
`define BUS_SW 4

// address split: tag on top, offset below
`define TAG_W 8
`define OFS_W 24

// region tags
`define TAG_RAM 8'h00
`define TAG_SYS 8'h10
`define TAG_EXT 8'h80

`define RAM_WORDS 256
`define EXT_WORDS 1024
`define EXT_WAIT 3     // idle cycles before the external ack

// system register offsets
`define SYS_CNT_OFS 24'h000000
`define SYS_BTN_OFS 24'h000004
`define SYS_SCR_OFS 24'h000008

`endif

/* hw/soc_bus_pkg.sv */
`include "soc_bus_defs.svh"

package soc_bus_pkg;

    // one bus address, seen either flat or as region tag plus offset
    typedef struct packed {
        logic [`TAG_W-1:0] tag;     // selects the slave
        logic [`OFS_W-1:0] offset;  // byte offset inside the region
    } bus_addr_fields_t;

    typedef union packed {
        logic [`BUS_AW-1:0] word;
        bus_addr_fields_t   fields;
    } bus_addr_u;

endpackage

/* hw/sys_regs.sv */
`include "soc_bus_defs.svh"

module sys_regs (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    wb_if.slave  bus
);

    logic [`BUS_DW-1:0] cycle_cnt;
    logic [`BUS_DW-1:0] scratch;
    logic               btn_meta;
    logic               btn_sync;
    logic               go;
    logic [`BUS_DW-1:0] rd_q;
    logic               ack_q;
    logic [`OFS_W-1:0]  ofs;

    assign ofs = bus.adr.fields.offset;
    assign go  = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            scratch   <= '0;
            btn_meta  <= 1'b0;
            btn_sync  <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;  // free running, not writable
            btn_meta  <= btn;               // two-flop synchroniser
            btn_sync  <= btn_meta;
            ack_q     <= go;
            // only the scratch word takes writes
            if (go && bus.we && ofs == `SYS_SCR_OFS) begin
                for (int b = 0; b < `BUS_SW; b++) begin
                    if (bus.sel[b]) begin
                        scratch[8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go && !bus.we) begin
            case (ofs)
                `SYS_CNT_OFS: rd_q <= cycle_cnt;
                `SYS_BTN_OFS: rd_q <= {{(`BUS_DW-1){1'b0}}, btn_sync};
                `SYS_SCR_OFS: rd_q <= scratch;
                default:      rd_q <= '0;  // hole in the register map
            endcase
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_q;

endmodule

/* hw/wb_if.sv */
`include "soc_bus_defs.svh"

interface wb_if import soc_bus_pkg::*; ();

    // request side
    logic               cyc;
    logic               stb;
    logic               we;
    bus_addr_u          adr;
    logic [`BUS_DW-1:0] dat_w;
    logic [`BUS_SW-1:0] sel;

    // response side
    logic [`BUS_DW-1:0] dat_r;   // valid only while ack is high
    logic               ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

    // observe only, used by the response merger
    modport monitor (
        input cyc, stb, we, adr, dat_w, sel, dat_r, ack
    );

endinterface

/* soc_bus.f */
+incdir+hw
hw/soc_bus_pkg.sv
hw/wb_if.sv
hw/bus_decode.sv
hw/data_ram.sv
hw/ext_mem.sv
hw/sys_regs.sv
hw/bus_result.sv
hw/soc_bus.sv
tests/tb_clock.sv
tests/soc_bus_asserts.sv
tests/soc_bus_tb.sv

/* tests/soc_bus_asserts.sv */
module soc_bus_asserts (
    input logic clk,
    input logic rst,
    input logic ack,
    input logic err,
    input logic ram_ack,
    input logic ext_ack,
    input logic sys_ack,
    input logic any_stb
);
    timeunit 1ns;
    timeprecision 1ps;

    // a cycle ends one way only
    ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(ack && err))
        else $error("ack and err high in the same cycle");

    ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held longer than one cycle");

    err_pulse: assert property (@(posedge clk) disable iff (rst) err |=> !err)
        else $error("err held longer than one cycle");

    one_slave: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ram_ack, ext_ack, sys_ack}))
        else $error("more than one slave acked in the same cycle");

    // every response is registered off a strobe one edge earlier
    no_stray: assert property (@(posedge clk) disable iff (rst) (ack || err) |-> $past(any_stb))
        else $error("response without a preceding strobe");

endmodule

/* tests/soc_bus_tb.sv */
`include "soc_bus_defs.svh"

module soc_bus_tb import soc_bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RND_WORDS = 32;

    typedef struct {
        string              name;
        logic               we;
        logic [`TAG_W-1:0]  tag;
        logic [`OFS_W-1:0]  offset;
        logic [`BUS_DW-1:0] dat_w;
        logic [`BUS_SW-1:0] sel;
        logic               btn;
        logic               chk;      // compare read data
        logic [`BUS_DW-1:0] exp_dat;
        logic               exp_err;
    } step_t;

    logic               clk;
    logic               rst;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [`BUS_AW-1:0] adr;
    logic [`BUS_DW-1:0] dat_w;
    logic [`BUS_SW-1:0] sel;
    logic               btn;
    logic [`BUS_DW-1:0] dat_r;
    logic               ack;
    logic               err;

    step_t              steps[$];
    logic [`BUS_DW-1:0] ram_shadow [`RAM_WORDS];
    logic [`BUS_DW-1:0] ext_shadow [`EXT_WORDS];
    logic               rnd_ext[$];
    int                 rnd_idx[$];
    int                 mismatches = 0;
    int                 other_errors = 0;
    int                 cycles = 0;
    int                 cycle_limit = 0;

    tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

    soc_bus dut0 (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .btn   (btn),
        .dat_r (dat_r),
        .ack   (ack),
        .err   (err)
    );

    bind bus_result soc_bus_asserts u_asserts (
        .clk     (clk),
        .rst     (rst),
        .ack     (ack),
        .err     (err),
        .ram_ack (ram_r.ack),
        .ext_ack (ext_r.ack),
        .sys_ack (sys_r.ack),
        .any_stb (ram_r.stb | ext_r.stb | sys_r.stb | miss_stb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_step(input string n, input logic w, input logic [`TAG_W-1:0] t,
                            input logic [`OFS_W-1:0] o, input logic [`BUS_DW-1:0] d,
                            input logic [`BUS_SW-1:0] s, input logic b, input logic c,
                            input logic [`BUS_DW-1:0] e, input logic ee);
        step_t st;
        st.name    = n;
        st.we      = w;
        st.tag     = t;
        st.offset  = o;
        st.dat_w   = d;
        st.sel     = s;
        st.btn     = b;
        st.chk     = c;
        st.exp_dat = e;
        st.exp_err = ee;
        steps.push_back(st);
    endtask

    // one classic cycle, ends on ack or err
    task automatic bus_cycle(input logic wr, input bus_addr_u a, input logic [`BUS_DW-1:0] d,
                             input logic [`BUS_SW-1:0] s, output logic [`BUS_DW-1:0] rd,
                             output logic got_ack, output logic got_err);
        @(posedge clk);
        #2;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a.word;
        dat_w = d;
        sel   = s;
        @(negedge clk);
        while (!(ack || err)) @(negedge clk);  // sampled mid-cycle
        rd      = dat_r;
        got_ack = ack;
        got_err = err;
        @(posedge clk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic check_read(input string n, input logic [`BUS_DW-1:0] exp_v,
                              input logic [`BUS_DW-1:0] act_v);
        if (act_v !== exp_v) begin
            mismatches++;
            $display("Mismatch %s: expected %08h, actual %08h", n, exp_v, act_v);
        end
    endtask

    task automatic check_err(input string n, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            mismatches++;
            $display("Mismatch %s: expected %0b, actual %0b", n, exp_v, act_v);
        end
    endtask

    always @(posedge clk) cycles <= cycles + 1;

    initial begin : watchdog
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        $display("timeout: bus stopped responding after %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        bus_addr_u          a;
        logic [`BUS_DW-1:0] rd;
        logic [`BUS_DW-1:0] c1;
        logic [`BUS_DW-1:0] wd;
        logic               got_ack;
        logic               got_err;
        logic [31:0]        r;
        logic               is_ext;
        int                 idx;

        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
        btn   = 1'b0;

        add_step("ram_wr", 1, `TAG_RAM, 24'h10, 32'hdeadbeef, 4'hf, 0, 0, 0, 0);
        add_step("ram_rd", 0, `TAG_RAM, 24'h10, 0, 4'hf, 0, 1, 32'hdeadbeef, 0);
        add_step("ram_wr_base", 1, `TAG_RAM, 24'h20, 32'h11223344, 4'hf, 0, 0, 0, 0);
        add_step("ram_wr_sel5", 1, `TAG_RAM, 24'h20, 32'haabbccdd, 4'b0101, 0, 0, 0, 0);
        add_step("ram_rd_sel5", 0, `TAG_RAM, 24'h20, 0, 4'hf, 0, 1,
                 {8'h11, 8'hbb, 8'h33, 8'hdd}, 0);
        add_step("ext_wr", 1, `TAG_EXT, 24'h40, 32'hcafef00d, 4'hf, 0, 0, 0, 0);
        add_step("ext_wr_top", 1, `TAG_EXT, 24'hffc, 32'h0badc0de, 4'hf, 0, 0, 0, 0);
        add_step("ext_rd", 0, `TAG_EXT, 24'h40, 0, 4'hf, 0, 1, 32'hcafef00d, 0);
        add_step("ext_rd_top", 0, `TAG_EXT, 24'hffc, 0, 4'hf, 0, 1, 32'h0badc0de, 0);
        add_step("ext_rd_wrap", 0, `TAG_EXT, 24'h1040, 0, 4'hf, 0, 1, 32'hcafef00d, 0);
        add_step("scr_wr", 1, `TAG_SYS, `SYS_SCR_OFS, 32'h11223344, 4'hf, 0, 0, 0, 0);
        add_step("scr_wr_mask", 1, `TAG_SYS, `SYS_SCR_OFS, 32'haabbccdd, 4'b0110, 0, 0, 0, 0);
        add_step("scr_rd", 0, `TAG_SYS, `SYS_SCR_OFS, 0, 4'hf, 0, 1,
                 {8'h11, 8'hbb, 8'hcc, 8'h44}, 0);
        add_step("cnt_wr", 1, `TAG_SYS, `SYS_CNT_OFS, 32'h80000000, 4'hf, 0, 0, 0, 0);
        add_step("hole_rd", 0, `TAG_SYS, 24'hc, 0, 4'hf, 0, 1, 32'h0, 0);
        add_step("btn_hi_rd", 0, `TAG_SYS, `SYS_BTN_OFS, 0, 4'hf, 1, 1, 32'h1, 0);
        add_step("btn_lo_rd", 0, `TAG_SYS, `SYS_BTN_OFS, 0, 4'hf, 0, 1, 32'h0, 0);
        add_step("miss_rd", 0, 8'h40, 24'h10, 0, 4'hf, 0, 1, 32'h0, 1);
        add_step("miss_wr", 1, 8'h40, 24'h10, 32'h12345678, 4'hf, 0, 0, 0, 1);
        add_step("ram_rd_after_miss", 0, `TAG_RAM, 24'h10, 0, 4'hf, 0, 1, 32'hdeadbeef, 0);

        // table, counter pair, random writes and reads
        cycle_limit = (steps.size() + 2 + 2 * RND_WORDS) * (`EXT_WAIT + 4) + 100;

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        foreach (steps[i]) begin
            if (steps[i].btn !== btn) begin
                @(posedge clk);
                #2;
                btn = steps[i].btn;
                repeat (4) @(posedge clk);  // through the synchroniser
            end
            a.fields.tag    = steps[i].tag;
            a.fields.offset = steps[i].offset;
            bus_cycle(steps[i].we, a, steps[i].dat_w, steps[i].sel, rd, got_ack, got_err);
            if (steps[i].chk) begin
                check_read(steps[i].name, steps[i].exp_dat, rd);
            end
            check_err(steps[i].name, steps[i].exp_err, got_err);
            check_err({steps[i].name, "_ack"}, !steps[i].exp_err, got_ack);
        end

        // counter keeps running after the ignored write
        a.fields.tag    = `TAG_SYS;
        a.fields.offset = `SYS_CNT_OFS;
        bus_cycle(1'b0, a, '0, 4'hf, c1, got_ack, got_err);
        bus_cycle(1'b0, a, '0, 4'hf, rd, got_ack, got_err);
        // counts from reset, so never ahead of the elapsed clock edges
        if (c1 > 32'(cycles)) begin
            other_errors++;
            $display("cycle counter took the write: read %0d after %0d cycles", c1, cycles);
        end
        if (rd <= c1) begin
            other_errors++;
            $display("cycle counter did not increase: first %0d, then %0d", c1, rd);
        end

        r = 32'd15382;
        for (int i = 0; i < RND_WORDS; i++) begin
            r = xorshift32(r);
            is_ext = r[31];
            idx = is_ext ? int'(r[9:0]) : int'(r[7:0]);
            r = xorshift32(r);
            a.fields.tag    = is_ext ? `TAG_EXT : `TAG_RAM;
            a.fields.offset = `OFS_W'(idx * 4);
            bus_cycle(1'b1, a, r, 4'hf, rd, got_ack, got_err);
            check_err($sformatf("rnd_wr%0d", i), 1'b0, got_err);
            if (is_ext) ext_shadow[idx] = r;
            else ram_shadow[idx] = r;
            rnd_ext.push_back(is_ext);
            rnd_idx.push_back(idx);
        end

        foreach (rnd_idx[i]) begin
            a.fields.tag    = rnd_ext[i] ? `TAG_EXT : `TAG_RAM;
            a.fields.offset = `OFS_W'(rnd_idx[i] * 4);
            wd = rnd_ext[i] ? ext_shadow[rnd_idx[i]] : ram_shadow[rnd_idx[i]];
            bus_cycle(1'b0, a, '0, 4'hf, rd, got_ack, got_err);
            check_read($sformatf("rnd_rd%0d", i), wd, rd);
        end

        $display("done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // first rising edge at half a period
    end

endmodule
